// ==== rtl/shell_rf_pkg.sv ====
/* Register file dimensions and word types. The reduced configuration
   keeps only the lower RfNumRegsE registers. Register 0 is never stored
   and always reads zero. */

`default_nettype none

package shell_rf_pkg;

  // Word and address widths
  localparam int unsigned RfDataW    = 32;
  localparam int unsigned RfAddrW    = 5;

  // Full and reduced register counts
  localparam int unsigned RfNumRegs  = 32;
  localparam int unsigned RfNumRegsE = 16;

  typedef logic [RfDataW-1:0] rf_data_t;
  typedef logic [RfAddrW-1:0] rf_addr_t;

endpackage

`default_nettype wire

// ==== rtl/shell_scr_pkg.sv ====
/* Scramble key and nonce widths. The defaults are the values the key
   and nonce registers hold until the first key is delivered. */

`default_nettype none

package shell_scr_pkg;

  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef logic [ScrKeyW-1:0]   scr_key_t;
  typedef logic [ScrNonceW-1:0] scr_nonce_t;

  // Fixed reset values held until the first fresh key
  localparam scr_key_t   ScrKeyDefault   = 128'h3ac9_8d4f_1be2_6057_c4a1_9e3d_72f0_5b86;
  localparam scr_nonce_t ScrNonceDefault = 64'h6d1e_f0a3_52b7_c948;

endpackage

`default_nettype wire

// ==== rtl/rf_if.sv ====
/* Register file port bundle. Two combinational read ports and one
   write port; the write is taken on the register file's own clock. */

`timescale 1ns/1ns
`default_nettype none

interface rf_if;
  import shell_rf_pkg::*;

  rf_addr_t raddr_a;
  rf_addr_t raddr_b;
  rf_addr_t waddr;
  logic     we;
  rf_data_t wdata;
  rf_data_t rdata_a;
  rf_data_t rdata_b;

  // Core side drives addresses and write data
  modport core (
    output raddr_a, raddr_b, waddr, we, wdata,
    input  rdata_a, rdata_b
  );

  modport regfile (
    input  raddr_a, raddr_b, waddr, we, wdata,
    output rdata_a, rdata_b
  );

endinterface

`default_nettype wire

// ==== rtl/sleep_ctrl.sv ====
/* Main clock gate. Busy reaches core_sleep_o one cycle late, wake-ups act
   at once. test_en_i opens the gate but does not affect core_sleep_o. */

`timescale 1ns/1ns
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic en_latched;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Enable sampled in the low phase so the gated high pulse is never cut short
  always_latch begin
    if (!clk_i) begin
      en_latched <= clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latched;

endmodule

`default_nettype wire

// ==== rtl/scramble_key_mgr.sv ====
/* Scramble key request and key store, on the ungated clock. A request
   is held until scramble_key_valid_i is seen; any strobe loads the key,
   requested or not. There is no back-pressure. */

`timescale 1ns/1ns
`default_nettype none

module scramble_key_mgr (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      icache_inval_i,
  input  logic                      scramble_key_valid_i,
  input  shell_scr_pkg::scr_key_t   scramble_key_i,
  input  shell_scr_pkg::scr_nonce_t scramble_nonce_i,
  output logic                      scramble_req_o,
  output logic                      scr_key_valid_o,
  output shell_scr_pkg::scr_key_t   scr_key_o,
  output shell_scr_pkg::scr_nonce_t scr_nonce_o
);
  import shell_scr_pkg::*;

  logic       req_d, req_q;
  logic       key_valid_d, key_valid_q;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  //////////////////////////////////////////////////////////////////////
  // Request and key-valid state
  //////////////////////////////////////////////////////////////////////

  // Request opens on invalidate and closes on the first valid strobe
  assign req_d = req_q ? ~scramble_key_valid_i : icache_inval_i;

  // Valid tracks the strobe while requesting, drops on invalidate
  assign key_valid_d = req_q          ? scramble_key_valid_i :
                       icache_inval_i ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Key and nonce store
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= ScrKeyDefault;
      nonce_q <= ScrNonceDefault;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o  = req_q;
  assign scr_key_valid_o = key_valid_q;
  assign scr_key_o       = key_q;
  assign scr_nonce_o     = nonce_q;

endmodule

`default_nettype wire

// ==== rtl/reg_file_ff.sv ====
/* Flip-flop register file, two read ports and one write port. Runs on
   the gated clock, so a write with the gate closed is lost. With Rv32e
   set, registers 16 to 31 read zero and ignore writes. */

`timescale 1ns/1ns
`default_nettype none

module reg_file_ff #(
  parameter bit Rv32e = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  rf_if.regfile rf
);
  import shell_rf_pkg::*;

  // Every word seen by the read muxes with unused ones tied to zero
  rf_data_t reg_word [RfNumRegs];

  assign reg_word[0] = '0;

  for (genvar i = 1; i < RfNumRegs; i++) begin : gen_reg
    if (Rv32e && (i >= RfNumRegsE)) begin : gen_tied
      assign reg_word[i] = '0;
    end else begin : gen_ff
      logic     we;
      rf_data_t word_q;

      // Write enable decode for this register
      assign we = rf.we & (rf.waddr == RfAddrW'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          word_q <= '0;
        end else if (we) begin
          word_q <= rf.wdata;
        end
      end

      assign reg_word[i] = word_q;
    end
  end

  // Combinational read ports
  assign rf.rdata_a = reg_word[rf.raddr_a];
  assign rf.rdata_b = reg_word[rf.raddr_b];

endmodule

`default_nettype wire

// ==== rtl/core_shell_top.sv ====
/* Shell around a processor core: main clock gate, flip-flop register
   file on the gated clock and scramble key manager on clk_i. The core
   is external and drives the rf_* and wake-up ports directly. */

`timescale 1ns/1ns
`default_nettype none

module core_shell_top #(
  parameter bit Rv32e = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      test_en_i,

  // Busy and wake-up levels
  input  logic                      core_busy_i,
  input  logic                      debug_req_i,
  input  logic                      irq_pending_i,
  input  logic                      irq_nm_i,
  output logic                      core_sleep_o,

  // Register file ports
  input  shell_rf_pkg::rf_addr_t    rf_raddr_a_i,
  input  shell_rf_pkg::rf_addr_t    rf_raddr_b_i,
  input  shell_rf_pkg::rf_addr_t    rf_waddr_i,
  input  logic                      rf_we_i,
  input  shell_rf_pkg::rf_data_t    rf_wdata_i,
  output shell_rf_pkg::rf_data_t    rf_rdata_a_o,
  output shell_rf_pkg::rf_data_t    rf_rdata_b_o,

  // Scramble key source and key outputs
  input  logic                      icache_inval_i,
  input  logic                      scramble_key_valid_i,
  input  shell_scr_pkg::scr_key_t   scramble_key_i,
  input  shell_scr_pkg::scr_nonce_t scramble_nonce_i,
  output logic                      scramble_req_o,
  output logic                      scr_key_valid_o,
  output shell_scr_pkg::scr_key_t   scr_key_o,
  output shell_scr_pkg::scr_nonce_t scr_nonce_o
);

  logic clk_gated;

  rf_if rf_bus ();

  //////////////////////////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////////////////////////

  sleep_ctrl i_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_gated_o  (clk_gated),
    .core_sleep_o (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  assign rf_bus.raddr_a = rf_raddr_a_i;
  assign rf_bus.raddr_b = rf_raddr_b_i;
  assign rf_bus.waddr   = rf_waddr_i;
  assign rf_bus.we      = rf_we_i;
  assign rf_bus.wdata   = rf_wdata_i;
  assign rf_rdata_a_o   = rf_bus.rdata_a;
  assign rf_rdata_b_o   = rf_bus.rdata_b;

  reg_file_ff #(
    .Rv32e(Rv32e)
  ) i_reg_file_ff (
    .clk_i (clk_gated),
    .rst_ni(rst_ni),
    .rf    (rf_bus.regfile)
  );

  //////////////////////////////////////////////////////////////////////
  // Scramble key manager
  //////////////////////////////////////////////////////////////////////

  scramble_key_mgr i_scramble_key_mgr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

endmodule

`default_nettype wire

// ==== sim/core_shell_props.sv ====
/* Concurrent checks, bound into sleep_ctrl and into scramble_key_mgr.
   Each bind ties off the inputs that belong to the other block, so
   those checks hold vacuously there. */

`timescale 1ns/1ns
`default_nettype none

module core_shell_props (
  input logic clk_i,
  input logic rst_ni,
  input logic core_busy_i,
  input logic core_sleep_i,
  input logic icache_inval_i,
  input logic scramble_req_i,
  input logic key_valid_i
);

  // Key never marked valid while a request is open
  req_blocks_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) scramble_req_i |-> !key_valid_i
  ) else $error("scr_key_valid_o high while scramble_req_o is open");

  // Busy keeps the core awake from the next cycle
  busy_wakes_core: assert property (
    @(posedge clk_i) disable iff (!rst_ni) core_busy_i |=> !core_sleep_i
  ) else $error("core_sleep_o high one cycle after core_busy_i");

  req_needs_inval: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(scramble_req_i) |-> $past(icache_inval_i)
  ) else $error("scramble_req_o rose without an icache_inval_i pulse");

endmodule

bind sleep_ctrl core_shell_props i_sleep_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .core_busy_i   (core_busy_i),
  .core_sleep_i  (core_sleep_o),
  .icache_inval_i(1'b0),
  .scramble_req_i(1'b0),
  .key_valid_i   (1'b0)
);

bind scramble_key_mgr core_shell_props i_key_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .core_busy_i   (1'b0),
  .core_sleep_i  (1'b1),
  .icache_inval_i(icache_inval_i),
  .scramble_req_i(scramble_req_o),
  .key_valid_i   (scr_key_valid_o)
);

`default_nettype wire

// ==== sim/core_shell_tb.sv ====
/* Testbench for core_shell_top with Rv32e = 0. It plays the core on the
   register file and wake-up ports and acts as the key source. A
   reference model is compared with the DUT on every falling edge. */

`timescale 1ns/1ns
`default_nettype none

module core_shell_tb;
  import shell_rf_pkg::*;
  import shell_scr_pkg::*;

  localparam bit          Rv32e      = 1'b0;
  localparam int unsigned ClkPeriod  = 20;
  localparam int unsigned NumWrites  = 200;
  localparam int unsigned NumKeyReq  = 8;
  // Summed upper bound of cycles over reset and all tests
  localparam int unsigned TestCycles = 8 + 2 + (NumWrites + 8) + 30 + NumKeyReq * 16 + 24;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       test_en_i;
  logic       core_busy_i;
  logic       debug_req_i;
  logic       irq_pending_i;
  logic       irq_nm_i;
  logic       core_sleep_o;
  rf_addr_t   rf_raddr_a_i;
  rf_addr_t   rf_raddr_b_i;
  rf_addr_t   rf_waddr_i;
  logic       rf_we_i;
  rf_data_t   rf_wdata_i;
  rf_data_t   rf_rdata_a_o;
  rf_data_t   rf_rdata_b_o;
  logic       icache_inval_i;
  logic       scramble_key_valid_i;
  scr_key_t   scramble_key_i;
  scr_nonce_t scramble_nonce_i;
  logic       scramble_req_o;
  logic       scr_key_valid_o;
  scr_key_t   scr_key_o;
  scr_nonce_t scr_nonce_o;

  logic [31:0] rng_state = 32'd57607;
  string       test_name = "init";

  // Reference model state
  rf_data_t   model_regs [RfNumRegs];
  logic       model_busy_q;
  logic       model_req;
  logic       model_valid;
  scr_key_t   model_key;
  scr_nonce_t model_nonce;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  core_shell_top #(
    .Rv32e(Rv32e)
  ) i_core_shell_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .test_en_i           (test_en_i),
    .core_busy_i         (core_busy_i),
    .debug_req_i         (debug_req_i),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .core_sleep_o        (core_sleep_o),
    .rf_raddr_a_i        (rf_raddr_a_i),
    .rf_raddr_b_i        (rf_raddr_b_i),
    .rf_waddr_i          (rf_waddr_i),
    .rf_we_i             (rf_we_i),
    .rf_wdata_i          (rf_wdata_i),
    .rf_rdata_a_o        (rf_rdata_a_o),
    .rf_rdata_b_o        (rf_rdata_b_o),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference functions
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic random_key(output scr_key_t key, output scr_nonce_t nonce);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      next_rand(w);
      key[32*i +: 32] = w;
    end
    for (int i = 0; i < 2; i++) begin
      next_rand(w);
      nonce[32*i +: 32] = w;
    end
  endtask

  // x0 and, in the reduced file, the upper half always read zero
  function automatic rf_data_t expected_read(input rf_addr_t addr);
    if (addr == '0) return '0;
    if (Rv32e && (addr >= RfAddrW'(RfNumRegsE))) return '0;
    return model_regs[addr];
  endfunction

  // Next {request, key valid} from the current state and inputs
  function automatic logic [1:0] next_key_state(input logic req, input logic valid,
                                                input logic inval, input logic strobe);
    if (req) return {~strobe, strobe};
    if (inval) return 2'b10;
    return {1'b0, valid};
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
    stop_run($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                       test_name, what, exp, act));
  endtask

  task automatic check_value(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp) else report_mismatch(what, exp, act);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare process
  //////////////////////////////////////////////////////////////////////

  // Inputs seen here are the ones the DUT samples on this edge
  always @(posedge clk_i or negedge rst_ni) begin : reference_model
    if (!rst_ni) begin
      for (int i = 0; i < RfNumRegs; i++) model_regs[i] = '0;
      model_busy_q = 1'b0;
      model_req    = 1'b0;
      model_valid  = 1'b1;
      model_key    = ScrKeyDefault;
      model_nonce  = ScrNonceDefault;
    end else begin
      // Gate opened by the enable held through the low phase
      if (rf_we_i && (model_busy_q | debug_req_i | irq_pending_i | irq_nm_i | test_en_i)) begin
        model_regs[rf_waddr_i] = rf_wdata_i;
      end
      model_busy_q = core_busy_i;
      {model_req, model_valid} = next_key_state(model_req, model_valid, icache_inval_i,
                                                scramble_key_valid_i);
      if (scramble_key_valid_i) begin
        model_key   = scramble_key_i;
        model_nonce = scramble_nonce_i;
      end
    end
  end

  always @(negedge clk_i) begin : compare_outputs
    logic exp_sleep;
    exp_sleep = ~(model_busy_q | debug_req_i | irq_pending_i | irq_nm_i);
    if (rst_ni) begin
      check_value("core_sleep_o", 128'(exp_sleep), 128'(core_sleep_o));
      check_value("rf_rdata_a_o", 128'(expected_read(rf_raddr_a_i)), 128'(rf_rdata_a_o));
      check_value("rf_rdata_b_o", 128'(expected_read(rf_raddr_b_i)), 128'(rf_rdata_b_o));
      check_value("scramble_req_o", 128'(model_req), 128'(scramble_req_o));
      check_value("scr_key_valid_o", 128'(model_valid), 128'(scr_key_valid_o));
      check_value("scr_key_o", model_key, scr_key_o);
      check_value("scr_nonce_o", 128'(model_nonce), 128'(scr_nonce_o));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Wake by debug or NMI alone, then write x5 through the opened gate
  task automatic check_wake_write(input bit use_debug);
    logic [31:0] r;
    @(posedge clk_i);
    if (use_debug) debug_req_i <= 1'b1;
    else irq_nm_i <= 1'b1;
    @(negedge clk_i);
    check_value("core_sleep_o on wake-up", 128'(1'b0), 128'(core_sleep_o));
    next_rand(r);
    @(posedge clk_i);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= 5'd5;
    rf_wdata_i <= r;
    @(posedge clk_i);
    rf_we_i     <= 1'b0;
    debug_req_i <= 1'b0;
    irq_nm_i    <= 1'b0;
    @(negedge clk_i);
    check_value("x5 after wake-up write", 128'(r), 128'(rf_rdata_a_o));
  endtask

  initial begin : stimulus
    logic [31:0] r;
    rf_addr_t    waddr;
    rf_addr_t    last_waddr;
    rf_data_t    old_val;
    int unsigned wait_cycles;
    scr_key_t    key;
    scr_nonce_t  nonce;

    rst_ni               <= 1'b0;
    test_en_i            <= 1'b0;
    core_busy_i          <= 1'b0;
    debug_req_i          <= 1'b0;
    irq_pending_i        <= 1'b0;
    irq_nm_i             <= 1'b0;
    rf_raddr_a_i         <= '0;
    rf_raddr_b_i         <= '0;
    rf_waddr_i           <= '0;
    rf_we_i              <= 1'b0;
    rf_wdata_i           <= '0;
    icache_inval_i       <= 1'b0;
    scramble_key_valid_i <= 1'b0;
    scramble_key_i       <= '0;
    scramble_nonce_i     <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "reset";
    @(negedge clk_i);
    check_value("scramble_req_o", 128'(1'b0), 128'(scramble_req_o));
    check_value("scr_key_valid_o", 128'(1'b1), 128'(scr_key_valid_o));
    check_value("scr_key_o", ScrKeyDefault, scr_key_o);
    check_value("scr_nonce_o", 128'(ScrNonceDefault), 128'(scr_nonce_o));
    check_value("core_sleep_o", 128'(1'b1), 128'(core_sleep_o));

    test_name = "regfile";
    @(posedge clk_i);
    core_busy_i <= 1'b1;
    last_waddr = '0;
    for (int i = 0; i < NumWrites; i++) begin
      @(posedge clk_i);
      next_rand(r);
      waddr = (i % 16 == 0) ? '0 : r[4:0];
      rf_we_i      <= 1'b1;
      rf_waddr_i   <= waddr;
      rf_raddr_a_i <= last_waddr;
      next_rand(r);
      rf_wdata_i   <= r;
      rf_raddr_b_i <= r[31:27];
      last_waddr = waddr;
    end
    @(posedge clk_i);
    rf_waddr_i   <= '0;
    rf_wdata_i   <= 32'hffff_ffff;
    rf_raddr_a_i <= '0;
    @(posedge clk_i);
    rf_we_i <= 1'b0;
    @(negedge clk_i);
    check_value("x0 after write", 128'(0), 128'(rf_rdata_a_o));

    test_name = "sleep";
    @(posedge clk_i);
    core_busy_i  <= 1'b0;
    rf_raddr_a_i <= 5'd5;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("core_sleep_o with no wake-up", 128'(1'b1), 128'(core_sleep_o));
    old_val = expected_read(5'd5);
    @(posedge clk_i);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= 5'd5;
    rf_wdata_i <= ~old_val;
    @(posedge clk_i);
    rf_we_i <= 1'b0;
    @(negedge clk_i);
    check_value("x5 after gated write", 128'(old_val), 128'(rf_rdata_a_o));
    check_wake_write(1'b0);
    check_wake_write(1'b1);
    @(posedge clk_i);
    core_busy_i <= 1'b1;
    @(negedge clk_i);
    check_value("core_sleep_o before busy register", 128'(1'b1), 128'(core_sleep_o));
    @(negedge clk_i);
    check_value("core_sleep_o after busy register", 128'(1'b0), 128'(core_sleep_o));

    test_name = "key_request";
    for (int n = 0; n < NumKeyReq; n++) begin
      @(posedge clk_i);
      icache_inval_i <= 1'b1;
      @(posedge clk_i);
      icache_inval_i <= 1'b0;
      @(negedge clk_i);
      check_value("scramble_req_o after invalidate", 128'(1'b1), 128'(scramble_req_o));
      check_value("scr_key_valid_o after invalidate", 128'(1'b0), 128'(scr_key_valid_o));
      next_rand(r);
      wait_cycles = r % 11;
      repeat (wait_cycles) begin
        @(negedge clk_i);
        check_value("scramble_req_o while waiting", 128'(1'b1), 128'(scramble_req_o));
      end
      random_key(key, nonce);
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b1;
      scramble_key_i       <= key;
      scramble_nonce_i     <= nonce;
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b0;
      @(negedge clk_i);
      check_value("scramble_req_o after key", 128'(1'b0), 128'(scramble_req_o));
      check_value("scr_key_valid_o after key", 128'(1'b1), 128'(scr_key_valid_o));
      check_value("scr_key_o after key", key, scr_key_o);
      check_value("scr_nonce_o after key", 128'(nonce), 128'(scr_nonce_o));
    end

    test_name = "key_capture";
    for (int n = 0; n < 3; n++) begin
      random_key(key, nonce);
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b1;
      scramble_key_i       <= key;
      scramble_nonce_i     <= nonce;
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b0;
      scramble_key_i       <= ~key;
      scramble_nonce_i     <= ~nonce;
      repeat (3) begin
        @(negedge clk_i);
        check_value("scr_key_o held", key, scr_key_o);
        check_value("scr_nonce_o held", 128'(nonce), 128'(scr_nonce_o));
      end
    end

    repeat (2) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

  initial begin : watchdog
    #(2 * TestCycles * ClkPeriod);
    stop_run("Timeout: the tests did not finish within their cycle budget");
  end

endmodule

`default_nettype wire

// ==== core_shell.f ====
rtl/shell_rf_pkg.sv
rtl/shell_scr_pkg.sv
rtl/rf_if.sv
rtl/sleep_ctrl.sv
rtl/scramble_key_mgr.sv
rtl/reg_file_ff.sv
rtl/core_shell_top.sv
sim/core_shell_props.sv
sim/core_shell_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core shell testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module core_shell_tb \
  -f core_shell.f -o core_shell_sim \
  && ./obj_dir/core_shell_sim > sim.log 2>&1 \
  || echo "Simulation build or run returned an error"
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log 2>/dev/null && exit 0 || exit 1
